//--- common/mipsPkg.sv
`default_nettype none

package mipsPkg;

	localparam int numRegs = 32;

	typedef logic [31:0] wordT;
	typedef logic [29:0] wordAddrT;
	typedef logic [$clog2(numRegs)-1:0] regIdxT;

	typedef enum logic [5:0] {
		opRType = 6'd0,
		opJ     = 6'd2,
		opBeq   = 6'd4,
		opAddi  = 6'd8,
		opLw    = 6'd35,
		opSw    = 6'd43
	} opcodeT;

	typedef enum logic [5:0] {
		fnAdd = 6'd32,
		fnSub = 6'd34,
		fnAnd = 6'd36,
		fnOr  = 6'd37,
		fnSlt = 6'd42
	} functT;

	// aluFunct defers the choice to the R-type function code in execute
	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt,
		aluFunct
	} aluOpT;

	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic memToReg; // load data instead of alu result
	} ctrlT;

	localparam wordT nopWord = '0;

endpackage

`default_nettype wire

//--- common/pipeIf.sv
`timescale 1ns/100ps
`default_nettype none

interface decodeExIf;
	import mipsPkg::*;

	ctrlT ctrl;
	aluOpT aluOp;
	logic useImm;
	wordT readData1;
	wordT readData2;
	wordT immediate; // sign extended, funct sits in the low bits
	regIdxT rs;
	regIdxT rt;
	regIdxT destReg;

	modport decodeSide (output ctrl, aluOp, useImm, readData1, readData2,
		immediate, rs, rt, destReg);
	modport executeSide (input ctrl, aluOp, useImm, readData1, readData2,
		immediate, rs, rt, destReg);
endinterface

interface forwardIf;
	import mipsPkg::*;

	regIdxT memDest;
	wordT memValue;
	logic memRegWrite;
	logic memIsLoad;
	regIdxT wbDest;
	wordT wbValue;
	logic wbRegWrite;

	modport producer (output memDest, memValue, memRegWrite, memIsLoad,
		wbDest, wbValue, wbRegWrite);
	modport consumer (input memDest, memValue, memRegWrite, memIsLoad,
		wbDest, wbValue, wbRegWrite);
endinterface

`default_nettype wire

//--- decode/registerFile.sv
`timescale 1ns/100ps
`default_nettype none

module registerFile (
	input logic clk,
	input logic rst_n,
	input logic freeze,
	input mipsPkg::regIdxT readIdx1,
	input mipsPkg::regIdxT readIdx2,
	output mipsPkg::wordT readData1,
	output mipsPkg::wordT readData2,
	input logic writeEn,
	input mipsPkg::regIdxT writeIdx,
	input mipsPkg::wordT writeData
);
	import mipsPkg::*;

	wordT regs [numRegs];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < numRegs; i++)
				regs[i] <= '0;
		end else if (writeEn && !freeze && writeIdx != '0) begin
			regs[writeIdx] <= writeData; // r0 stays zero
		end
	end

	// write-through so decode sees the value retiring this cycle
	assign readData1 = (writeEn && writeIdx == readIdx1 && readIdx1 != '0) ?
		writeData : regs[readIdx1];
	assign readData2 = (writeEn && writeIdx == readIdx2 && readIdx2 != '0) ?
		writeData : regs[readIdx2];

endmodule

`default_nettype wire

//--- decode/decodeStage.sv
`timescale 1ns/100ps
`default_nettype none

module decodeStage #(
	parameter mipsPkg::wordT resetPc = '0
) (
	input logic clk,
	input logic rst_n,
	input logic freeze,
	output logic icacheRen,
	output mipsPkg::wordAddrT icacheAddr,
	input mipsPkg::wordT icacheRdata,
	decodeExIf.decodeSide decodeEx,
	forwardIf.consumer forward
);
	import mipsPkg::*;

	wordT ir;
	wordAddrT pc;
	wordAddrT nextPc;
	wordAddrT branchTarget;
	wordAddrT jumpTarget;
	opcodeT opcode;
	regIdxT rs;
	regIdxT rt;
	regIdxT srcRs;
	regIdxT srcRt;
	regIdxT idDest;
	regIdxT issueDest;
	regIdxT exDest; // copy of what execute holds
	ctrlT idCtrl;
	ctrlT issueCtrl;
	aluOpT idAluOp;
	logic idUseImm;
	logic isBeq;
	logic isJump;
	logic exIsLoad;
	logic loadUse;
	logic branchHazard;
	logic hazard;
	logic redirect;
	wordT immExt;
	wordT regData1;
	wordT regData2;

	// mem stage bypass for the branch compare, wb is covered by the register file
	function automatic wordT branchOperand(regIdxT src, wordT regValue);
		if (forward.memRegWrite && !forward.memIsLoad && forward.memDest == src && src != '0)
			return forward.memValue;
		return regValue;
	endfunction

	assign opcode = opcodeT'(ir[31:26]);
	assign rs = ir[25:21];
	assign rt = ir[20:16];
	assign immExt = {{16{ir[15]}}, ir[15:0]};

	always_comb begin
		idCtrl = '0;
		idAluOp = aluAdd;
		idUseImm = 1'b0;
		idDest = '0;
		srcRs = rs;
		srcRt = rt;
		isBeq = 1'b0;
		isJump = 1'b0;
		case (opcode)
			opRType: begin
				idCtrl.regWrite = 1'b1;
				idAluOp = aluFunct;
				idDest = ir[15:11];
			end
			opAddi, opLw: begin
				idCtrl.regWrite = 1'b1;
				idCtrl.memRead = (opcode == opLw);
				idCtrl.memToReg = (opcode == opLw);
				idUseImm = 1'b1;
				idDest = rt;
				srcRt = '0; // rt is the destination here
			end
			opSw: begin
				idCtrl.memWrite = 1'b1;
				idUseImm = 1'b1;
			end
			opBeq: begin
				idAluOp = aluSub;
				isBeq = 1'b1;
			end
			opJ: begin
				isJump = 1'b1;
				srcRs = '0;
				srcRt = '0;
			end
			default: begin
				srcRs = '0;
				srcRt = '0;
			end
		endcase
	end

	assign loadUse = exIsLoad && exDest != '0 && (exDest == srcRs || exDest == srcRt);
	// a load still in mem cannot feed the compare either
	assign branchHazard = isBeq && ((exDest != '0 && (exDest == rs || exDest == rt))
		|| (forward.memIsLoad && forward.memDest != '0
		&& (forward.memDest == rs || forward.memDest == rt)));
	assign hazard = loadUse || branchHazard;

	assign branchTarget = pc + wordAddrT'(immExt); // pc already points past the beq
	assign jumpTarget = {pc[29:26], ir[25:0]};
	assign redirect = !hazard && (isJump
		|| (isBeq && branchOperand(rs, regData1) == branchOperand(rt, regData2)));
	assign nextPc = redirect ? (isJump ? jumpTarget : branchTarget) : pc + 30'd1;

	assign issueCtrl = hazard ? ctrlT'('0) : idCtrl;
	assign issueDest = hazard ? '0 : idDest;

	assign decodeEx.ctrl = issueCtrl;
	assign decodeEx.aluOp = idAluOp;
	assign decodeEx.useImm = idUseImm;
	assign decodeEx.readData1 = regData1;
	assign decodeEx.readData2 = regData2;
	assign decodeEx.immediate = immExt;
	assign decodeEx.rs = srcRs;
	assign decodeEx.rt = srcRt;
	assign decodeEx.destReg = issueDest;

	assign icacheAddr = pc;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			icacheRen <= 1'b0;
			pc <= resetPc[31:2];
			ir <= nopWord;
			exDest <= '0;
			exIsLoad <= 1'b0;
		end else begin
			icacheRen <= 1'b1;
			if (!freeze) begin
				exDest <= issueDest;
				exIsLoad <= issueCtrl.memRead;
				if (!hazard) begin
					pc <= nextPc;
					ir <= redirect ? nopWord : icacheRdata; // flush the slot behind a taken jump
				end
			end
		end
	end

	registerFile i_registerFile (
		.clk(clk),
		.rst_n(rst_n),
		.freeze(freeze),
		.readIdx1(rs),
		.readIdx2(rt),
		.readData1(regData1),
		.readData2(regData2),
		.writeEn(forward.wbRegWrite),
		.writeIdx(forward.wbDest),
		.writeData(forward.wbValue)
	);

endmodule

`default_nettype wire

//--- rtl/executeStage.sv
`timescale 1ns/100ps
`default_nettype none

module executeStage (
	input logic clk,
	input logic rst_n,
	input logic freeze,
	decodeExIf.executeSide decodeEx,
	forwardIf.consumer forward,
	output mipsPkg::ctrlT exCtrl,
	output mipsPkg::wordT aluResult,
	output mipsPkg::wordT storeData,
	output mipsPkg::regIdxT exDest
);
	import mipsPkg::*;

	ctrlT ctrl;
	aluOpT aluOp;
	aluOpT op;
	logic useImm;
	regIdxT rs;
	regIdxT rt;
	regIdxT destReg;
	wordT readData1;
	wordT readData2;
	wordT immediate;
	wordT opA;
	wordT opB;
	wordT aluIn2;
	wordT result;
	functT funct;

	function automatic wordT pickOperand(regIdxT src, wordT regValue);
		if (src == '0)
			return regValue;
		if (forward.memRegWrite && forward.memDest == src) // mem is younger, wins
			return forward.memValue;
		if (forward.wbRegWrite && forward.wbDest == src)
			return forward.wbValue;
		return regValue;
	endfunction

	function automatic aluOpT functOp(functT f);
		case (f)
			fnSub: return aluSub;
			fnAnd: return aluAnd;
			fnOr: return aluOr;
			fnSlt: return aluSlt;
			default: return aluAdd;
		endcase
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl <= '0;
			aluOp <= aluAdd;
			useImm <= 1'b0;
			rs <= '0;
			rt <= '0;
			destReg <= '0;
		end else if (!freeze) begin
			ctrl <= decodeEx.ctrl;
			aluOp <= decodeEx.aluOp;
			useImm <= decodeEx.useImm;
			rs <= decodeEx.rs;
			rt <= decodeEx.rt;
			destReg <= decodeEx.destReg;
		end
	end

	always_ff @(posedge clk) begin
		if (!freeze) begin
			readData1 <= decodeEx.readData1;
			readData2 <= decodeEx.readData2;
			immediate <= decodeEx.immediate;
		end
	end

	assign funct = functT'(immediate[5:0]);
	assign op = (aluOp == aluFunct) ? functOp(funct) : aluOp;
	assign opA = pickOperand(rs, readData1);
	assign opB = pickOperand(rt, readData2);
	assign aluIn2 = useImm ? immediate : opB;

	always_comb begin
		case (op)
			aluSub: result = opA - aluIn2;
			aluAnd: result = opA & aluIn2;
			aluOr: result = opA | aluIn2;
			aluSlt: result = wordT'($signed(opA) < $signed(aluIn2));
			default: result = opA + aluIn2;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			exCtrl <= '0;
			exDest <= '0;
		end else if (!freeze) begin
			exCtrl <= ctrl;
			exDest <= destReg;
		end
	end

	always_ff @(posedge clk) begin
		if (!freeze) begin
			aluResult <= result;
			storeData <= opB; // forwarded rt for sw
		end
	end

endmodule

`default_nettype wire

//--- rtl/memoryStage.sv
`timescale 1ns/100ps
`default_nettype none

module memoryStage (
	input logic clk,
	input logic rst_n,
	input logic freeze,
	input mipsPkg::ctrlT exCtrl,
	input mipsPkg::wordT aluResult,
	input mipsPkg::wordT storeData,
	input mipsPkg::regIdxT exDest,
	output logic dcacheRen,
	output logic dcacheWen,
	output mipsPkg::wordAddrT dcacheAddr,
	output mipsPkg::wordT dcacheWdata,
	input mipsPkg::wordT dcacheRdata,
	forwardIf.producer forward
);
	import mipsPkg::*;

	wordT memValue;
	wordT wbValue;
	regIdxT wbDest;
	logic wbRegWrite;

	assign dcacheRen = exCtrl.memRead;
	assign dcacheWen = exCtrl.memWrite;
	assign dcacheAddr = aluResult[31:2]; // word address
	assign dcacheWdata = storeData;

	assign memValue = exCtrl.memToReg ? dcacheRdata : aluResult;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wbDest <= '0;
			wbRegWrite <= 1'b0;
		end else if (!freeze) begin
			wbDest <= exDest;
			wbRegWrite <= exCtrl.regWrite;
		end
	end

	always_ff @(posedge clk) begin
		if (!freeze)
			wbValue <= memValue;
	end

	assign forward.memDest = exDest;
	assign forward.memValue = memValue;
	assign forward.memRegWrite = exCtrl.regWrite;
	assign forward.memIsLoad = exCtrl.memRead;
	assign forward.wbDest = wbDest;
	assign forward.wbValue = wbValue;
	assign forward.wbRegWrite = wbRegWrite;

endmodule

`default_nettype wire

//--- rtl/mipsPipeline.sv
`timescale 1ns/100ps
`default_nettype none

module mipsPipeline #(
	parameter mipsPkg::wordT resetPc = '0
) (
	input logic clk,
	input logic rst_n,
	output logic icacheRen,
	output mipsPkg::wordAddrT icacheAddr,
	input mipsPkg::wordT icacheRdata,
	input logic icacheStall,
	output logic dcacheRen,
	output logic dcacheWen,
	output mipsPkg::wordAddrT dcacheAddr,
	output mipsPkg::wordT dcacheWdata,
	input mipsPkg::wordT dcacheRdata,
	input logic dcacheStall
);
	import mipsPkg::*;

	logic freeze;
	ctrlT exCtrl;
	wordT aluResult;
	wordT storeData;
	regIdxT exDest;

	decodeExIf decodeEx ();
	forwardIf forward ();

	assign freeze = icacheStall | dcacheStall; // either cache holds the whole pipe

	decodeStage #(
		.resetPc(resetPc)
	) i_decodeStage (
		.clk(clk),
		.rst_n(rst_n),
		.freeze(freeze),
		.icacheRen(icacheRen),
		.icacheAddr(icacheAddr),
		.icacheRdata(icacheRdata),
		.decodeEx(decodeEx.decodeSide),
		.forward(forward.consumer)
	);

	executeStage i_executeStage (
		.clk(clk),
		.rst_n(rst_n),
		.freeze(freeze),
		.decodeEx(decodeEx.executeSide),
		.forward(forward.consumer),
		.exCtrl(exCtrl),
		.aluResult(aluResult),
		.storeData(storeData),
		.exDest(exDest)
	);

	memoryStage i_memoryStage (
		.clk(clk),
		.rst_n(rst_n),
		.freeze(freeze),
		.exCtrl(exCtrl),
		.aluResult(aluResult),
		.storeData(storeData),
		.exDest(exDest),
		.dcacheRen(dcacheRen),
		.dcacheWen(dcacheWen),
		.dcacheAddr(dcacheAddr),
		.dcacheWdata(dcacheWdata),
		.dcacheRdata(dcacheRdata),
		.forward(forward.producer)
	);

endmodule

`default_nettype wire

//--- test/pipeline_properties.sv
`timescale 1ns/100ps
`default_nettype none

module pipelineProperties (
	input logic clk,
	input logic rst_n,
	input logic icacheRen,
	input mipsPkg::wordAddrT icacheAddr,
	input logic icacheStall,
	input logic dcacheRen,
	input logic dcacheWen,
	input mipsPkg::wordAddrT dcacheAddr,
	input mipsPkg::wordT dcacheWdata,
	input logic dcacheStall
);

	int violations = 0; // read by the testbench top

	quietInReset: assert property (@(posedge clk)
		!rst_n |-> !icacheRen && !dcacheRen && !dcacheWen)
	else begin
		$error("cache enable high during reset");
		violations++;
	end

	quietAfterReset: assert property (@(posedge clk)
		$rose(rst_n) |-> !icacheRen && !dcacheRen && !dcacheWen)
	else begin
		$error("cache enable high in the first edge after reset");
		violations++;
	end

	// fetch runs from the second edge after reset on
	fetchEnabled: assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n) |-> icacheRen)
	else begin
		$error("icacheRen low after reset");
		violations++;
	end

	// a stalled edge leaves the ports as they were
	holdWhileStalled: assert property (@(posedge clk) disable iff (!rst_n)
		(icacheStall || dcacheStall) |=> $stable(icacheAddr) && $stable(dcacheAddr)
		&& $stable(dcacheWen) && $stable(dcacheWdata))
	else begin
		$error("cache port changed while stalled");
		violations++;
	end

	noDualAccess: assert property (@(posedge clk) disable iff (!rst_n)
		!(dcacheRen && dcacheWen))
	else begin
		$error("dcacheRen and dcacheWen high together");
		violations++;
	end

endmodule

bind mipsPipeline pipelineProperties i_properties (
	.clk(clk),
	.rst_n(rst_n),
	.icacheRen(icacheRen),
	.icacheAddr(icacheAddr),
	.icacheStall(icacheStall),
	.dcacheRen(dcacheRen),
	.dcacheWen(dcacheWen),
	.dcacheAddr(dcacheAddr),
	.dcacheWdata(dcacheWdata),
	.dcacheStall(dcacheStall)
);

`default_nettype wire

//--- test/tbClock.sv
`timescale 1ns/100ps
`default_nettype none

module tbClock #(
	parameter int periodNs = 4,
	parameter int resetCycles = 2
) (
	output logic clk,
	output logic rst_n,
	input logic rerun
);

	initial begin
		clk = 1'b0;
		forever #(periodNs / 2) clk = ~clk;
	end

	// reset again whenever rerun rises
	initial begin
		rst_n = 1'b0;
		forever begin
			repeat (resetCycles) @(posedge clk);
			#1 rst_n = 1'b1;
			@(posedge rerun);
			rst_n = 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- test/tbMipsPipeline.sv
`timescale 1ns/100ps
`default_nettype none

module tbMipsPipeline;
	import mipsPkg::*;

	localparam int memWords = 64;
	localparam int numStores = 10;
	localparam int cycleLimit = 600;

	// hand-computed stores in program order
	localparam wordAddrT expAddr [numStores] = '{
		30'd7, 30'd6, 30'd1, 30'd2, 30'd3, 30'd4, 30'd5, 30'd8, 30'd11, 30'd14
	};
	localparam wordT expData [numStores] = '{
		32'd1, 32'd22, 32'd6, 32'd15, 32'd21, 32'hFFFF_FFFA, 32'd16,
		32'hA000_2ABE, 32'd21, 32'd22
	};

	logic clk;
	logic rst_n;
	logic rerun;
	logic icacheRen;
	wordAddrT icacheAddr;
	wordT icacheRdata;
	logic icacheStall;
	logic dcacheRen;
	logic dcacheWen;
	wordAddrT dcacheAddr;
	wordT dcacheWdata;
	wordT dcacheRdata;
	logic dcacheStall;

	wordT rom [memWords];
	wordT ram [memWords];
	int storeCount = 0;
	int errors = 0;
	int testsRun = 0;
	int testsFailed = 0;
	int cycles = 0;
	logic stallsOn = 1'b0;

	tbClock #(.periodNs(4), .resetCycles(2)) i_clock (
		.clk(clk),
		.rst_n(rst_n),
		.rerun(rerun)
	);

	mipsPipeline #(.resetPc(32'd0)) i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.icacheRen(icacheRen),
		.icacheAddr(icacheAddr),
		.icacheRdata(icacheRdata),
		.icacheStall(icacheStall),
		.dcacheRen(dcacheRen),
		.dcacheWen(dcacheWen),
		.dcacheAddr(dcacheAddr),
		.dcacheWdata(dcacheWdata),
		.dcacheRdata(dcacheRdata),
		.dcacheStall(dcacheStall)
	);

	assign icacheRdata = rom[icacheAddr[5:0]];
	assign dcacheRdata = dcacheRen ? ram[dcacheAddr[5:0]] : '0; // same-cycle answer

	function automatic wordT rTypeWord(regIdxT rd, regIdxT rs, regIdxT rt, functT fn);
		return {opRType, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic wordT immWord(opcodeT op, regIdxT rt, regIdxT rs, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic wordT jumpWord(logic [25:0] target);
		return {opJ, target};
	endfunction

	function automatic int totalErrors();
		return errors + i_dut.i_properties.violations;
	endfunction

	task automatic loadProgram();
		for (int i = 0; i < memWords; i++)
			rom[i] = nopWord;
		rom[0] = immWord(opAddi, 5'd1, 5'd0, 16'd6);
		rom[1] = immWord(opAddi, 5'd2, 5'd1, 16'd9);
		rom[2] = rTypeWord(5'd3, 5'd1, 5'd2, fnAdd);
		rom[3] = rTypeWord(5'd4, 5'd2, 5'd3, fnSub);
		rom[4] = rTypeWord(5'd5, 5'd4, 5'd3, fnAnd);
		rom[5] = rTypeWord(5'd6, 5'd5, 5'd1, fnOr);
		rom[6] = rTypeWord(5'd7, 5'd4, 5'd6, fnSlt);
		rom[7] = immWord(opSw, 5'd7, 5'd0, 16'd28); // data from mem stage
		rom[8] = immWord(opSw, 5'd6, 5'd0, 16'd24); // data from wb stage
		rom[9] = immWord(opSw, 5'd1, 5'd0, 16'd4);
		rom[10] = immWord(opSw, 5'd2, 5'd0, 16'd8);
		rom[11] = immWord(opSw, 5'd3, 5'd0, 16'd12);
		rom[12] = immWord(opSw, 5'd4, 5'd0, 16'd16);
		rom[13] = immWord(opSw, 5'd5, 5'd0, 16'd20);
		rom[14] = immWord(opLw, 5'd8, 5'd0, 16'd160);
		rom[15] = rTypeWord(5'd9, 5'd8, 5'd6, fnAdd); // load-use
		rom[16] = immWord(opSw, 5'd9, 5'd0, 16'd32);
		rom[17] = immWord(opAddi, 5'd10, 5'd0, 16'd22);
		rom[18] = immWord(opBeq, 5'd6, 5'd10, 16'd2); // taken and depends on 17
		rom[19] = immWord(opSw, 5'd1, 5'd0, 16'd36); // flushed slot
		rom[20] = immWord(opSw, 5'd2, 5'd0, 16'd40); // skipped path
		rom[21] = immWord(opBeq, 5'd2, 5'd1, 16'd5); // not taken
		rom[22] = immWord(opSw, 5'd3, 5'd0, 16'd44);
		rom[23] = jumpWord(26'd26);
		rom[24] = immWord(opSw, 5'd4, 5'd0, 16'd48);
		rom[25] = immWord(opSw, 5'd5, 5'd0, 16'd52);
		rom[26] = immWord(opSw, 5'd10, 5'd0, 16'd56);
		rom[27] = jumpWord(26'd27); // park here
	endtask

	task automatic fillMemory();
		for (int i = 0; i < memWords; i++)
			ram[i] = 32'hA000_0000 + i * 32'h111;
	endtask

	task automatic checkStore(wordAddrT addr, wordT data);
		assert (storeCount < numStores) else begin
			$display("unexpected extra store of %h to word %0d at %0t", data, addr, $time);
			errors++;
		end
		if (storeCount < numStores) begin
			assert (addr == expAddr[storeCount] && data == expData[storeCount]) else begin
				$display("[FAIL] %0t store %0d wrote %h to word %0d, expected %h to word %0d",
					$time, storeCount, data, addr, expData[storeCount], expAddr[storeCount]);
				errors++;
			end
		end
		storeCount++;
	endtask

	task automatic checkStoreTotal();
		assert (storeCount == numStores) else begin
			$display("[FAIL] %0t saw %0d stores, expected %0d", $time, storeCount, numStores);
			errors++;
		end
	endtask

	task automatic reportTest(string name, int errorsBefore);
		testsRun++;
		if (totalErrors() == errorsBefore) begin
			$display("test %0d %s: passed", testsRun, name);
		end else begin
			testsFailed++;
			$display("test %0d %s: %0d errors", testsRun, name, totalErrors() - errorsBefore);
		end
	endtask

	// a store counts at the edge where the pipe is not frozen
	always @(negedge clk) begin
		if (rst_n && dcacheWen && !icacheStall && !dcacheStall) begin
			ram[dcacheAddr[5:0]] = dcacheWdata;
			checkStore(dcacheAddr, dcacheWdata);
		end
	end

	initial begin
		icacheStall = 1'b0;
		dcacheStall = 1'b0;
		void'($urandom(13));
		forever begin
			@(posedge clk);
			#1;
			icacheStall = stallsOn && ($urandom % 3 == 0);
			dcacheStall = stallsOn && ($urandom % 3 == 0);
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycleLimit) begin
			$display("timeout: the program did not finish within %0d cycles", cycleLimit);
			$display("Something failed");
			$finish;
		end
	end

	initial begin
		int mark;

		rerun = 1'b0;
		loadProgram();
		fillMemory();

		mark = totalErrors();
		@(posedge rst_n);
		@(negedge clk);
		assert (icacheAddr == '0) else begin
			$display("[FAIL] %0t first fetch address %0d, expected 0", $time, icacheAddr);
			errors++;
		end
		@(negedge clk);
		reportTest("reset", mark);

		mark = totalErrors();
		wait (storeCount >= 7);
		reportTest("arithmetic and forwarding", mark);

		mark = totalErrors();
		wait (storeCount >= 8);
		reportTest("load-use", mark);

		mark = totalErrors();
		wait (storeCount >= numStores);
		repeat (20) @(negedge clk);
		checkStoreTotal();
		reportTest("control flow", mark);

		// second pass under random stalls
		mark = totalErrors();
		@(posedge clk);
		#1;
		storeCount = 0;
		fillMemory();
		stallsOn = 1'b1;
		rerun = 1'b1;
		@(posedge rst_n);
		rerun = 1'b0;
		wait (storeCount >= numStores);
		repeat (30) @(negedge clk);
		checkStoreTotal();
		stallsOn = 1'b0;
		reportTest("back-pressure", mark);

		repeat (4) @(negedge clk);
		reportTest("port sanity", errors);

		$display("%0d tests run, %0d failed, %0d check errors, %0d property failures",
			testsRun, testsFailed, errors, i_dut.i_properties.violations);
		if (testsFailed == 0 && totalErrors() == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
common/mipsPkg.sv
common/pipeIf.sv
decode/registerFile.sv
decode/decodeStage.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/mipsPipeline.sv
test/pipeline_properties.sv
test/tbClock.sv
test/tbMipsPipeline.sv
